// File: hdl/sim_mem_defines.svh
// ~~~~~~~~~~~~~~~~~~~~
// Sizing macros for the simulation memory.
// Bus widths, memory depth, address window and response depth.
// ~~~~~~~~~~~~~~~~~~~~

`ifndef SIM_MEM_DEFINES_SVH
`define SIM_MEM_DEFINES_SVH

// Bus address width in bits.
`define SIM_MEM_AW 32

// Bus and memory data width in bits.
`define SIM_MEM_DW 32

// Number of 32-bit words in the SRAM.
`define SIM_MEM_DEPTH 16

// Start of the decoded window, aligned to DEPTH*4 bytes.
`define SIM_MEM_BASE 32'h1000_0000

// Requests a port may hold between acceptance and response.
`define SIM_MEM_OUTSTANDING 2

`endif

// File: hdl/bus_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// Host bus types.
// Request and response opcodes and the channel structs.
// ~~~~~~~~~~~~~~~~~~~~

`include "sim_mem_defines.svh"

package bus_pkg;

  // Request opcodes.
  // Code 2'd3 is left free and treated as illegal.
  typedef enum logic [1:0] {
    PUT_FULL    = 2'd0,
    PUT_PARTIAL = 2'd1,
    GET         = 2'd2
  } bus_opcode_e;

  // Response opcodes.
  typedef enum logic {
    ACCESS_ACK      = 1'b0,
    ACCESS_ACK_DATA = 1'b1
  } rsp_opcode_e;

  // Request channel payload.
  typedef struct packed {
    bus_opcode_e               opcode;
    logic [`SIM_MEM_AW-1:0]    addr;
    logic [`SIM_MEM_DW-1:0]    data;
    logic [`SIM_MEM_DW/8-1:0]  mask;
  } bus_req_t;

  // Response channel payload.
  // Data is zero on errors and on put acks.
  typedef struct packed {
    rsp_opcode_e             opcode;
    logic [`SIM_MEM_DW-1:0]  data;
    logic                    error;
  } bus_rsp_t;

endpackage

// File: hdl/mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// SRAM side types.
// Word index, data, byte mask and arbiter state.
// ~~~~~~~~~~~~~~~~~~~~

`include "sim_mem_defines.svh"

package mem_pkg;

  // Index width for DEPTH words.
  localparam int unsigned MEM_AW = $clog2(`SIM_MEM_DEPTH);

  typedef logic [MEM_AW-1:0]         mem_addr_t;
  typedef logic [`SIM_MEM_DW-1:0]    mem_data_t;

  // One enable bit per byte lane.
  typedef logic [`SIM_MEM_DW/8-1:0]  mem_mask_t;

  // Port that won the last arbitration.
  typedef enum logic {
    LAST_P0 = 1'b0,
    LAST_P1 = 1'b1
  } arb_last_e;

endpackage

// File: hdl/mem_port_if.sv
// ~~~~~~~~~~~~~~~~~~~~
// One SRAM access port.
// Requester, arbiter and memory views.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface mem_port_if
  import mem_pkg::*;
();

  // Request side.
  logic       req;
  logic       we;
  mem_addr_t  addr;
  mem_data_t  wdata;
  mem_mask_t  wmask;

  // Return side.
  // Gnt is combinational in the request cycle.
  // Rvalid follows a granted read by one cycle.
  logic       gnt;
  logic       rvalid;
  mem_data_t  rdata;

  // Adapter, or arbiter toward the SRAM.
  modport requester (
    output req, we, addr, wdata, wmask,
    input  gnt, rvalid, rdata
  );

  // Arbiter facing one adapter.
  modport arbiter (
    input  req, we, addr, wdata, wmask,
    output gnt, rvalid, rdata
  );

  // SRAM view.
  // Rvalid is not used here, the arbiter tracks it.
  modport memory (
    input  req, we, addr, wdata, wmask,
    output gnt, rdata
  );

endinterface

// File: hdl/sram_1p.sv
// ~~~~~~~~~~~~~~~~~~~~
// Single-port SRAM model.
// Byte-masked writes, one-cycle registered reads.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "sim_mem_defines.svh"

module sram_1p
  import mem_pkg::*;
(
  input  logic       clk_i,
  mem_port_if.memory mem
);

  localparam int unsigned BYTES = $bits(mem_mask_t);

  mem_data_t  mem_q [`SIM_MEM_DEPTH];
  mem_data_t  rdata_q;

  // Never stalls.
  assign mem.gnt = 1'b1;

  // Write lands at the granted edge.
  // Read data is registered.
  always_ff @(posedge clk_i) begin
    if (mem.req) begin
      if (mem.we) begin
        for (int i = 0; i < BYTES; i++) begin
          if (mem.wmask[i]) begin
            mem_q[mem.addr][8*i +: 8] <= mem.wdata[8*i +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[mem.addr];
      end
    end
  end

  assign mem.rdata = rdata_q;

  // Arbiter never forwards an unknown access or an index past the array.
  a_addr_range: assert property (@(posedge clk_i)
    mem.req |-> !$isunknown({mem.we, mem.addr}) && (32'(mem.addr) < `SIM_MEM_DEPTH));

endmodule

// File: hdl/mem_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~
// Two-port round-robin arbiter.
// Forwards the winner to the SRAM and routes read data back.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mem_arbiter
  import mem_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,
  mem_port_if.arbiter   p0,
  mem_port_if.arbiter   p1,
  mem_port_if.requester mem
);

  arb_last_e  last_q;
  logic       pick_p1;
  logic       rvalid_p0_q;
  logic       rvalid_p1_q;

  // On contention the port not served last wins.
  always_comb begin
    if (p0.req && p1.req) begin
      pick_p1 = (last_q == LAST_P0);
    end else begin
      pick_p1 = p1.req;
    end
  end

  // Winner drives the SRAM port.
  assign mem.req   = p0.req || p1.req;
  assign mem.we    = pick_p1 ? p1.we    : p0.we;
  assign mem.addr  = pick_p1 ? p1.addr  : p0.addr;
  assign mem.wdata = pick_p1 ? p1.wdata : p0.wdata;
  assign mem.wmask = pick_p1 ? p1.wmask : p0.wmask;

  // Grants pass through the memory grant.
  assign p0.gnt = p0.req && !pick_p1 && mem.gnt;
  assign p1.gnt = p1.req && pick_p1 && mem.gnt;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_q      <= LAST_P1;
      rvalid_p0_q <= 1'b0;
      rvalid_p1_q <= 1'b0;
    end else begin
      if (p0.gnt) begin
        last_q <= LAST_P0;
      end else if (p1.gnt) begin
        last_q <= LAST_P1;
      end
      // Remember which port owns next cycle's read data.
      rvalid_p0_q <= p0.gnt && !p0.we;
      rvalid_p1_q <= p1.gnt && !p1.we;
    end
  end

  // Read data only shows on the owning port.
  assign p0.rvalid = rvalid_p0_q;
  assign p1.rvalid = rvalid_p1_q;
  assign p0.rdata  = rvalid_p0_q ? mem.rdata : '0;
  assign p1.rdata  = rvalid_p1_q ? mem.rdata : '0;

  // A port served in one cycle never blocks the other port in the next.
  // Only one of the two is granted then.
  a_turn_p1: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ($past(p0.gnt) && p1.req && mem.gnt) |-> (p1.gnt && !p0.gnt));

  a_turn_p0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ($past(p1.gnt) && p0.req && mem.gnt) |-> (p0.gnt && !p1.gnt));

endmodule

// File: hdl/bus_sram_adapter.sv
// ~~~~~~~~~~~~~~~~~~~~
// Bus to SRAM adapter.
// Window and opcode decode, access check, request stage, response FIFO.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "sim_mem_defines.svh"

module bus_sram_adapter
  import bus_pkg::*;
  import mem_pkg::*;
#(
  parameter bit ERR_ON_READ = 1'b0
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          a_valid_i,
  output logic          a_ready_o,
  input  bus_req_t      a_req_i,
  output logic          d_valid_o,
  input  logic          d_ready_i,
  output bus_rsp_t      d_rsp_o,
  mem_port_if.requester mem
);

  localparam int unsigned OUTS  = `SIM_MEM_OUTSTANDING;
  localparam int unsigned CNT_W = $clog2(OUTS + 1);
  localparam int unsigned PTR_W = (OUTS > 1) ? $clog2(OUTS) : 1;
  localparam int unsigned OFS_W = $clog2(`SIM_MEM_DEPTH) + 2;
  localparam logic [`SIM_MEM_AW-1:0] BASE_ADDR = `SIM_MEM_BASE;

  logic              a_fire;
  logic              d_fire;
  logic              legal_op;
  logic              in_window;
  logic              req_err;
  logic              stage_valid_q;
  logic              stage_err_q;
  logic              stage_we_q;
  logic              stage_get_q;
  mem_addr_t         stage_addr_q;
  mem_data_t         stage_wdata_q;
  mem_mask_t         stage_wmask_q;
  logic              stage_done;
  logic              mem_req;
  logic              push;
  bus_rsp_t          push_rsp;
  bus_rsp_t          rsp_q [OUTS];
  logic [PTR_W-1:0]  wptr_q;
  logic [PTR_W-1:0]  rptr_q;
  logic [CNT_W-1:0]  q_cnt_q;
  logic [CNT_W-1:0]  out_cnt_q;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(OUTS - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Opcode decode.
  always_comb begin
    case (a_req_i.opcode)
      PUT_FULL, PUT_PARTIAL, GET: legal_op = 1'b1;
      default:                    legal_op = 1'b0;
    endcase
  end

  // Window is aligned, so upper bits alone select it.
  assign in_window = (a_req_i.addr[`SIM_MEM_AW-1:OFS_W] == BASE_ADDR[`SIM_MEM_AW-1:OFS_W]);

  // Sunk requests get an error and skip the SRAM.
  assign req_err = !legal_op || !in_window || (ERR_ON_READ && (a_req_i.opcode == GET));

  // Request stage.
  // A write waits while a read result lands, so only one entry is queued per cycle.
  assign mem_req    = stage_valid_q && !stage_err_q && !(stage_we_q && mem.rvalid);
  assign stage_done = stage_valid_q && (stage_err_q ? !mem.rvalid : mem.gnt);

  // Accept only below the outstanding limit and with the stage free.
  assign a_ready_o = (out_cnt_q < CNT_W'(OUTS)) && (!stage_valid_q || stage_done);
  assign a_fire    = a_valid_i && a_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      stage_valid_q <= 1'b0;
      stage_err_q   <= 1'b0;
      stage_we_q    <= 1'b0;
    end else if (a_fire) begin
      stage_valid_q <= 1'b1;
      stage_err_q   <= req_err;
      stage_we_q    <= (a_req_i.opcode != GET);
    end else if (stage_done) begin
      stage_valid_q <= 1'b0;
    end
  end

  // Stage payload.
  // A full put writes every byte.
  always_ff @(posedge clk_i) begin
    if (a_fire) begin
      stage_get_q   <= (a_req_i.opcode == GET);
      stage_addr_q  <= mem_addr_t'(a_req_i.addr[OFS_W-1:2]);
      stage_wdata_q <= a_req_i.data;
      stage_wmask_q <= (a_req_i.opcode == PUT_FULL) ? '1 : a_req_i.mask;
    end
  end

  assign mem.req   = mem_req;
  assign mem.we    = stage_we_q;
  assign mem.addr  = stage_addr_q;
  assign mem.wdata = stage_wdata_q;
  assign mem.wmask = stage_wmask_q;

  // Response source, read data first to keep order.
  always_comb begin
    push     = 1'b0;
    push_rsp = '{opcode: ACCESS_ACK, data: '0, error: 1'b0};
    if (mem.rvalid) begin
      push            = 1'b1;
      push_rsp.opcode = ACCESS_ACK_DATA;
      push_rsp.data   = mem.rdata;
    end else if (stage_valid_q && stage_err_q) begin
      push            = 1'b1;
      push_rsp.opcode = stage_get_q ? ACCESS_ACK_DATA : ACCESS_ACK;
      push_rsp.error  = 1'b1;
    end else if (mem_req && mem.gnt && stage_we_q) begin
      // Write ack is queued at the grant.
      push = 1'b1;
    end
  end

  // Response FIFO.
  assign d_valid_o = (q_cnt_q != '0);
  assign d_rsp_o   = rsp_q[rptr_q];
  assign d_fire    = d_valid_o && d_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q    <= '0;
      rptr_q    <= '0;
      q_cnt_q   <= '0;
      out_cnt_q <= '0;
    end else begin
      if (push) begin
        wptr_q <= ptr_inc(wptr_q);
      end
      if (d_fire) begin
        rptr_q <= ptr_inc(rptr_q);
      end
      q_cnt_q   <= q_cnt_q + CNT_W'(push) - CNT_W'(d_fire);
      out_cnt_q <= out_cnt_q + CNT_W'(a_fire) - CNT_W'(d_fire);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      rsp_q[wptr_q] <= push_rsp;
    end
  end

  // A queued response always belongs to an accepted request.
  a_dvalid_queued: assert property (@(posedge clk_i) disable iff (!rst_ni)
    d_valid_o |-> (out_cnt_q != '0) && (q_cnt_q <= out_cnt_q));

  // Request and its address hold until the arbiter grants.
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req && !mem.gnt) |=> (mem_req && $stable(stage_addr_q)));

endmodule

// File: hdl/sim_mem_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// Simulation memory top.
// Two bus hosts, their adapters, arbiter and shared SRAM.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "sim_mem_defines.svh"

module sim_mem_top
  import bus_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Host 0 is the core side.
  input  logic                      h0_a_valid_i,
  output logic                      h0_a_ready_o,
  input  bus_opcode_e               h0_a_opcode_i,
  input  logic [`SIM_MEM_AW-1:0]    h0_a_addr_i,
  input  logic [`SIM_MEM_DW-1:0]    h0_a_data_i,
  input  logic [`SIM_MEM_DW/8-1:0]  h0_a_mask_i,
  output logic                      h0_d_valid_o,
  input  logic                      h0_d_ready_i,
  output rsp_opcode_e               h0_d_opcode_o,
  output logic [`SIM_MEM_DW-1:0]    h0_d_data_o,
  output logic                      h0_d_error_o,
  // Host 1 is the debug side.
  input  logic                      h1_a_valid_i,
  output logic                      h1_a_ready_o,
  input  bus_opcode_e               h1_a_opcode_i,
  input  logic [`SIM_MEM_AW-1:0]    h1_a_addr_i,
  input  logic [`SIM_MEM_DW-1:0]    h1_a_data_i,
  input  logic [`SIM_MEM_DW/8-1:0]  h1_a_mask_i,
  output logic                      h1_d_valid_o,
  input  logic                      h1_d_ready_i,
  output rsp_opcode_e               h1_d_opcode_o,
  output logic [`SIM_MEM_DW-1:0]    h1_d_data_o,
  output logic                      h1_d_error_o
);

  bus_req_t  h0_req;
  bus_req_t  h1_req;
  bus_rsp_t  h0_rsp;
  bus_rsp_t  h1_rsp;

  // Pack host requests.
  assign h0_req = '{opcode: h0_a_opcode_i, addr: h0_a_addr_i, data: h0_a_data_i,
                    mask: h0_a_mask_i};
  assign h1_req = '{opcode: h1_a_opcode_i, addr: h1_a_addr_i, data: h1_a_data_i,
                    mask: h1_a_mask_i};

  // Unpack responses.
  assign h0_d_opcode_o = h0_rsp.opcode;
  assign h0_d_data_o   = h0_rsp.data;
  assign h0_d_error_o  = h0_rsp.error;
  assign h1_d_opcode_o = h1_rsp.opcode;
  assign h1_d_data_o   = h1_rsp.data;
  assign h1_d_error_o  = h1_rsp.error;

  mem_port_if p0_if ();
  mem_port_if p1_if ();
  mem_port_if sram_if ();

  // Core side may only write.
  bus_sram_adapter #(
    .ERR_ON_READ(1'b1)
  ) u_adapter_p0 (
    .clk_i,
    .rst_ni,
    .a_valid_i(h0_a_valid_i),
    .a_ready_o(h0_a_ready_o),
    .a_req_i  (h0_req),
    .d_valid_o(h0_d_valid_o),
    .d_ready_i(h0_d_ready_i),
    .d_rsp_o  (h0_rsp),
    .mem      (p0_if.requester)
  );

  bus_sram_adapter #(
    .ERR_ON_READ(1'b0)
  ) u_adapter_p1 (
    .clk_i,
    .rst_ni,
    .a_valid_i(h1_a_valid_i),
    .a_ready_o(h1_a_ready_o),
    .a_req_i  (h1_req),
    .d_valid_o(h1_d_valid_o),
    .d_ready_i(h1_d_ready_i),
    .d_rsp_o  (h1_rsp),
    .mem      (p1_if.requester)
  );

  mem_arbiter u_arbiter (
    .clk_i,
    .rst_ni,
    .p0 (p0_if.arbiter),
    .p1 (p1_if.arbiter),
    .mem(sram_if.requester)
  );

  sram_1p u_sram (
    .clk_i,
    .mem(sram_if.memory)
  );

endmodule

// File: verif/tb_clock_gen.sv
// ~~~~~~~~~~~~~~~~~~~~
// Testbench clock and reset source.
// 100 ns clock, reset low for four cycles.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int unsigned HALF_PERIOD  = 50,
  parameter int unsigned RESET_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_no
);

  // Free running clock.
  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD) clk_o = ~clk_o;
  end

  // Reset released on a rising edge.
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: verif/tb_sim_mem.sv
// ~~~~~~~~~~~~~~~~~~~~
// Directed testbench for the two-host simulation memory.
// Reference memory model, response monitor, compare tasks, watchdog.
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps
`include "sim_mem_defines.svh"

module tb_sim_mem
  import bus_pkg::*;
();

  localparam int DEPTH = `SIM_MEM_DEPTH;
  localparam int HALF  = `SIM_MEM_DEPTH / 2;
  localparam logic [`SIM_MEM_AW-1:0] WIN_BASE = `SIM_MEM_BASE;
  localparam logic [`SIM_MEM_AW-1:0] WIN_SIZE = 32'(`SIM_MEM_DEPTH * 4);
  // Under 160 requests in all, each done within about 5 cycles, then a 5x margin.
  localparam int MAX_REQS       = 160;
  localparam int CYCLES_PER_REQ = 5;
  localparam int CYCLE_LIMIT    = MAX_REQS * CYCLES_PER_REQ * 5;

  logic                      clk;
  logic                      rst_n;
  logic                      h0_a_valid;
  logic                      h0_a_ready;
  bus_opcode_e               h0_a_opcode;
  logic [`SIM_MEM_AW-1:0]    h0_a_addr;
  logic [`SIM_MEM_DW-1:0]    h0_a_data;
  logic [`SIM_MEM_DW/8-1:0]  h0_a_mask;
  logic                      h0_d_valid;
  logic                      h0_d_ready;
  rsp_opcode_e               h0_d_opcode;
  logic [`SIM_MEM_DW-1:0]    h0_d_data;
  logic                      h0_d_error;
  logic                      h1_a_valid;
  logic                      h1_a_ready;
  bus_opcode_e               h1_a_opcode;
  logic [`SIM_MEM_AW-1:0]    h1_a_addr;
  logic [`SIM_MEM_DW-1:0]    h1_a_data;
  logic [`SIM_MEM_DW/8-1:0]  h1_a_mask;
  logic                      h1_d_valid;
  logic                      h1_d_ready;
  rsp_opcode_e               h1_d_opcode;
  logic [`SIM_MEM_DW-1:0]    h1_d_data;
  logic                      h1_d_error;

  // Reference memory and expected responses per host, oldest first.
  logic [`SIM_MEM_DW-1:0]    model [DEPTH];
  bus_rsp_t                  exp_q0 [$];
  bus_rsp_t                  exp_q1 [$];
  int                        seed;
  int                        err_cnt   = 0;
  int                        check_cnt = 0;
  int                        test_cnt  = 0;
  int                        fail_cnt  = 0;
  int                        cycle_cnt = 0;

  tb_clock_gen u_clock_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  sim_mem_top DUT (
    .clk_i(clk), .rst_ni(rst_n),
    .h0_a_valid_i(h0_a_valid), .h0_a_ready_o(h0_a_ready), .h0_a_opcode_i(h0_a_opcode),
    .h0_a_addr_i(h0_a_addr), .h0_a_data_i(h0_a_data), .h0_a_mask_i(h0_a_mask),
    .h0_d_valid_o(h0_d_valid), .h0_d_ready_i(h0_d_ready), .h0_d_opcode_o(h0_d_opcode),
    .h0_d_data_o(h0_d_data), .h0_d_error_o(h0_d_error),
    .h1_a_valid_i(h1_a_valid), .h1_a_ready_o(h1_a_ready), .h1_a_opcode_i(h1_a_opcode),
    .h1_a_addr_i(h1_a_addr), .h1_a_data_i(h1_a_data), .h1_a_mask_i(h1_a_mask),
    .h1_d_valid_o(h1_d_valid), .h1_d_ready_i(h1_d_ready), .h1_d_opcode_o(h1_d_opcode),
    .h1_d_data_o(h1_d_data), .h1_d_error_o(h1_d_error)
  );

  task automatic check_rsp_opcode(input string sig, input rsp_opcode_e got,
                                  input rsp_opcode_e exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t: %s got %s expected %s", $time, sig, got.name(), exp.name());
    end
  endtask

  task automatic check_data(input string sig, input logic [`SIM_MEM_DW-1:0] got,
                            input logic [`SIM_MEM_DW-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, sig, got, exp);
    end
  endtask

  task automatic check_error(input string sig, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, sig, got, exp);
    end
  endtask

  // Handshake level of a valid or ready line.
  task automatic check_flag(input string sig, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, sig, got, exp);
    end
  endtask

  function automatic logic [`SIM_MEM_AW-1:0] word_addr(input int idx);
    return WIN_BASE + 32'(idx) * 32'd4;
  endfunction

  // Expected response from the bus rules, with the model updated for a legal put.
  task automatic predict(input int port, input bus_opcode_e op,
                         input logic [`SIM_MEM_AW-1:0] addr,
                         input logic [`SIM_MEM_DW-1:0] data, input logic [3:0] mask);
    bus_rsp_t  rsp;
    logic      hit;
    logic      legal;
    int        idx;
    hit        = (addr >= WIN_BASE) && ((addr - WIN_BASE) < WIN_SIZE);
    legal      = (op == PUT_FULL) || (op == PUT_PARTIAL) || (op == GET);
    idx        = int'((addr - WIN_BASE) >> 2);
    rsp.opcode = (op == GET) ? ACCESS_ACK_DATA : ACCESS_ACK;
    rsp.data   = '0;
    // Core side is write only.
    rsp.error  = !hit || !legal || ((port == 0) && (op == GET));
    if (!rsp.error && (op == GET)) begin
      rsp.data = model[idx];
    end else if (!rsp.error) begin
      for (int b = 0; b < 4; b++) begin
        if ((op == PUT_FULL) || mask[b]) begin
          model[idx][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
    if (port == 0) begin
      exp_q0.push_back(rsp);
    end else begin
      exp_q1.push_back(rsp);
    end
  endtask

  // Hold a request until the host's a_ready accepts it.
  task automatic drive_req(input int port, input bus_opcode_e op,
                           input logic [`SIM_MEM_AW-1:0] addr,
                           input logic [`SIM_MEM_DW-1:0] data, input logic [3:0] mask);
    @(posedge clk);
    if (port == 0) begin
      h0_a_valid  <= 1'b1;
      h0_a_opcode <= op;
      h0_a_addr   <= addr;
      h0_a_data   <= data;
      h0_a_mask   <= mask;
    end else begin
      h1_a_valid  <= 1'b1;
      h1_a_opcode <= op;
      h1_a_addr   <= addr;
      h1_a_data   <= data;
      h1_a_mask   <= mask;
    end
    @(negedge clk);
    while (((port == 0) ? h0_a_ready : h1_a_ready) !== 1'b1) @(negedge clk);
    // Transfer happens on this edge.
    @(posedge clk);
    if (port == 0) begin
      h0_a_valid <= 1'b0;
    end else begin
      h1_a_valid <= 1'b0;
    end
  endtask

  task automatic issue(input int port, input bus_opcode_e op,
                       input logic [`SIM_MEM_AW-1:0] addr,
                       input logic [`SIM_MEM_DW-1:0] data, input logic [3:0] mask);
    predict(port, op, addr, data, mask);
    drive_req(port, op, addr, data, mask);
  endtask

  // Compare one response that transfers on the coming edge.
  task automatic take_rsp(input int port);
    bus_rsp_t     exp;
    rsp_opcode_e  got_op;
    logic [31:0]  got_data;
    logic         got_err;
    got_op   = (port == 0) ? h0_d_opcode : h1_d_opcode;
    got_data = (port == 0) ? h0_d_data : h1_d_data;
    got_err  = (port == 0) ? h0_d_error : h1_d_error;
    if (((port == 0) ? exp_q0.size() : exp_q1.size()) == 0) begin
      err_cnt++;
      $display("ERROR at %0t: host %0d returned a response nobody asked for", $time, port);
    end else begin
      exp = (port == 0) ? exp_q0.pop_front() : exp_q1.pop_front();
      check_rsp_opcode($sformatf("h%0d_d_opcode_o", port), got_op, exp.opcode);
      check_data($sformatf("h%0d_d_data_o", port), got_data, exp.data);
      check_error($sformatf("h%0d_d_error_o", port), got_err, exp.error);
    end
  endtask

  // Outputs are sampled mid-cycle.
  always @(negedge clk) begin
    if (rst_n && h0_d_valid && h0_d_ready) take_rsp(0);
    if (rst_n && h1_d_valid && h1_d_ready) take_rsp(1);
  end

  task automatic wait_idle();
    while ((exp_q0.size() != 0) || (exp_q1.size() != 0)) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int errs_before);
    wait_idle();
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("test %0d %s: FAILED, %0d errors", test_cnt, name, err_cnt - errs_before);
    end
  endtask

  task automatic test_full_write_read();
    int           errs_before;
    logic [31:0]  rnd;
    errs_before = err_cnt;
    for (int i = 0; i < DEPTH; i++) begin
      rnd = $random(seed);
      issue(1, PUT_FULL, word_addr(i), rnd, 4'h0);
    end
    for (int i = 0; i < DEPTH; i++) issue(1, GET, word_addr(i), '0, 4'h0);
    report_test("full write and read back", errs_before);
  endtask

  task automatic test_partial_write();
    int           errs_before;
    logic [31:0]  rnd;
    logic [31:0]  rnd_mask;
    errs_before = err_cnt;
    for (int i = 0; i < DEPTH; i++) begin
      rnd      = $random(seed);
      rnd_mask = $random(seed);
      issue(1, PUT_PARTIAL, word_addr(i), rnd, rnd_mask[3:0]);
    end
    for (int i = 0; i < DEPTH; i++) issue(1, GET, word_addr(i), '0, 4'h0);
    report_test("partial write with masks", errs_before);
  endtask

  task automatic test_core_write_only();
    int           errs_before;
    logic [31:0]  rnd;
    errs_before = err_cnt;
    rnd = $random(seed);
    issue(0, PUT_FULL, word_addr(5), rnd, 4'h0);
    wait_idle();
    // Core read must fail, debug read must see the core's write.
    issue(0, GET, word_addr(5), '0, 4'h0);
    wait_idle();
    issue(1, GET, word_addr(5), '0, 4'h0);
    report_test("core side write only", errs_before);
  endtask

  task automatic test_sunk_requests();
    int           errs_before;
    logic [31:0]  rnd;
    bus_opcode_e  bad_op;
    errs_before = err_cnt;
    bad_op = bus_opcode_e'(2'd3);
    rnd    = $random(seed);
    issue(0, PUT_FULL, WIN_BASE + WIN_SIZE, rnd, 4'hf);
    issue(1, PUT_FULL, WIN_BASE - 32'd4, rnd, 4'hf);
    issue(1, GET, 32'h0, '0, 4'h0);
    issue(1, bad_op, word_addr(3), rnd, 4'hf);
    issue(0, bad_op, word_addr(4), rnd, 4'hf);
    wait_idle();
    issue(1, GET, word_addr(3), '0, 4'h0);
    issue(1, GET, word_addr(4), '0, 4'h0);
    // Out-of-window puts would alias onto the first and last words.
    issue(1, GET, word_addr(0), '0, 4'h0);
    issue(1, GET, word_addr(DEPTH - 1), '0, 4'h0);
    report_test("sunk requests", errs_before);
  endtask

  task automatic test_both_hosts();
    int           errs_before;
    logic [31:0]  p0_data [HALF];
    logic [31:0]  p1_data [HALF];
    logic [31:0]  p1_mask [HALF];
    errs_before = err_cnt;
    for (int i = 0; i < HALF; i++) begin
      p0_data[i] = $random(seed);
      p1_data[i] = $random(seed);
      p1_mask[i] = $random(seed);
    end
    // Core owns the lower half, debug the upper half.
    fork
      begin
        for (int i = 0; i < HALF; i++) begin
          issue(0, PUT_FULL, word_addr(i), p0_data[i], 4'h0);
          if (i % 2 == 0) issue(0, GET, word_addr(i), '0, 4'h0);
        end
      end
      begin
        for (int i = 0; i < HALF; i++) begin
          issue(1, PUT_PARTIAL, word_addr(i + HALF), p1_data[i], p1_mask[i][3:0]);
          issue(1, GET, word_addr(i + HALF), '0, 4'h0);
        end
      end
    join
    wait_idle();
    for (int i = 0; i < HALF; i++) issue(1, GET, word_addr(i), '0, 4'h0);
    report_test("both hosts at once", errs_before);
  endtask

  task automatic test_back_pressure();
    int errs_before;
    errs_before = err_cnt;
    @(posedge clk);
    h1_d_ready <= 1'b0;
    issue(1, GET, word_addr(1), '0, 4'h0);
    issue(1, GET, word_addr(2), '0, 4'h0);
    // Two outstanding, so the host must stall with data waiting.
    repeat (4) begin
      @(negedge clk);
      check_flag("h1_a_ready_o", h1_a_ready, 1'b0);
      check_flag("h1_d_valid_o", h1_d_valid, 1'b1);
    end
    @(posedge clk);
    h1_d_ready <= 1'b1;
    issue(1, GET, word_addr(6), '0, 4'h0);
    issue(1, GET, word_addr(7), '0, 4'h0);
    report_test("back-pressure", errs_before);
  endtask

  initial begin : watchdog
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
    $display("** FAIL **");
    $finish;
  end

  initial begin : main_seq
    seed        = 32'hfd72_b609;
    h0_a_valid  = 1'b0;
    h0_a_opcode = PUT_FULL;
    h0_a_addr   = '0;
    h0_a_data   = '0;
    h0_a_mask   = '0;
    h0_d_ready  = 1'b1;
    h1_a_valid  = 1'b0;
    h1_a_opcode = PUT_FULL;
    h1_a_addr   = '0;
    h1_a_data   = '0;
    h1_a_mask   = '0;
    h1_d_ready  = 1'b1;
    for (int i = 0; i < DEPTH; i++) model[i] = '0;
    wait (rst_n == 1'b1);
    @(posedge clk);
    test_full_write_read();
    test_partial_write();
    test_core_write_only();
    test_sunk_requests();
    test_both_hosts();
    test_back_pressure();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             test_cnt, fail_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: sim_mem.f
+incdir+hdl
hdl/bus_pkg.sv
hdl/mem_pkg.sv
hdl/mem_port_if.sv
hdl/sram_1p.sv
hdl/mem_arbiter.sv
hdl/bus_sram_adapter.sv
hdl/sim_mem_top.sv
verif/tb_clock_gen.sv
verif/tb_sim_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the sim_mem testbench with Verilator.
# Exits nonzero unless the log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sim_mem.f --top-module tb_sim_mem -Mdir "$BUILD_DIR" -o Vtb_sim_mem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_sim_mem" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qxF '** PASS **' "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
